/* corr_ctrl_top.f */
cmd_pkg.sv
line_pkg.sv
line_cfg_if.sv
uart_rx.sv
cmd_parser.sv
pwm_bank.sv
corr_ctrl_top.sv
tb_corr_ctrl_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_corr_ctrl_top -f corr_ctrl_top.f
out=$(./obj_dir/Vtb_corr_ctrl_top)
echo "$out"
echo "$out" | grep -qx "TEST OK"

/* tb_corr_ctrl_top.sv */
//****************************************************************************
// Testbench for the correlator control front end. Sends serial command
// frames on rx and checks every output against a model of the command set.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_corr_ctrl_top;

	localparam int nl = line_pkg::num_lines;
	localparam int dw = line_pkg::dly_w;

	logic clk;
	logic rst;
	logic rx;
	logic [nl-1:0] pwm;
	logic [nl*line_pkg::test_w-1:0] test;
	logic [nl*line_pkg::led_w-1:0] leds;
	logic [nl*dw-1:0] cross_idx;
	logic [nl*dw-1:0] auto_idx;
	logic [nl*dw-1:0] cross_len;
	logic [nl*dw-1:0] auto_len;
	logic integrating;
	logic external_clock;
	logic timestamp_reset;
	logic extra_commands;

	// Expected state. exp_dly is indexed by target and then by line, the targets being
	// cross index, auto index, cross length and auto length.
	logic [7:0] cur_line;
	logic [cmd_pkg::baud_sel_w-1:0] tb_baud;
	logic [3:0] exp_flags; // Capture byte bits 7:4 as sent.
	logic [line_pkg::volt_w-1:0] exp_volt [nl];
	logic [line_pkg::test_w-1:0] exp_test [nl];
	logic [line_pkg::led_w-1:0] exp_leds [nl];
	logic [dw-1:0] exp_dly [4][nl];
	logic [nl-1:0] volt_zero;
	int seed;
	int errors;
	int frames_seen;
	bit settled;

	corr_ctrl_top corr_ctrl_top_i (
		.clk             (clk),
		.rst             (rst),
		.rx              (rx),
		.pwm             (pwm),
		.test            (test),
		.leds            (leds),
		.cross_idx       (cross_idx),
		.auto_idx        (auto_idx),
		.cross_len       (cross_len),
		.auto_len        (auto_len),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.extra_commands  (extra_commands)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (rst)
			frames_seen <= 0;
		else if (corr_ctrl_top_i.byte_valid)
			frames_seen <= frames_seen + 1; // Counts bytes handed to the parser.
	end

	always_comb begin
		for (int k = 0; k < nl; k++)
			volt_zero[k] = exp_volt[k] == '0;
	end

	assert property (@(posedge clk) disable iff (rst)
		settled |-> {extra_commands, timestamp_reset, external_clock, integrating} == exp_flags)
		else begin
			$display("FAIL {extra_commands, timestamp_reset, external_clock, integrating}: got %h expected %h",
				{extra_commands, timestamp_reset, external_clock, integrating}, exp_flags);
			errors++;
		end

	assert property (@(posedge clk) disable iff (rst) settled |-> (pwm & volt_zero) == '0)
		else begin
			$display("FAIL pwm: got %h with zero voltage on lines %h", pwm, volt_zero);
			errors++;
		end

	function automatic int cycles_per_bit(input logic [cmd_pkg::baud_sel_w-1:0] sel);
		int s;
		s = (sel > cmd_pkg::max_baud_sel) ? cmd_pkg::max_baud_sel : sel;
		return cmd_pkg::base_bit_cycles << s;
	endfunction

	task automatic apply_byte(input logic [7:0] b);
		logic [3:0] op;
		int l;
		int t;
		op = b[3:0];
		l = cur_line;
		t = {exp_flags[3], b[7]}; // Length when extra commands are on, auto on bit 7.
		if (op == cmd_pkg::op_set_line)
			cur_line[int'(b[7:6]) * 2 +: 2] = b[5:4];
		else if (op == cmd_pkg::op_enable_capture)
			exp_flags = b[7:4];
		else if (op == cmd_pkg::op_set_baud_rate)
			tb_baud = b[7:4];
		else if (l < nl) begin
			if (op == cmd_pkg::op_clear) begin
				exp_dly[0][l] = '0;
				exp_dly[1][l] = '0;
			end else if (op == cmd_pkg::op_set_voltage)
				exp_volt[l][int'(b[7:6]) * 2 +: 2] = b[5:4];
			else if (op == cmd_pkg::op_enable_test)
				exp_test[l][(exp_flags[3] ? 4 : 0) +: 4] = b[7:4];
			else if (op == cmd_pkg::op_set_leds)
				exp_leds[l][(exp_flags[3] ? 4 : 0) +: 4] = b[7:4];
			else if (op[3:2] == 2'b01)
				exp_dly[t][l][int'(b[1:0]) * 3 +: 3] = b[6:4];
			else if (op == cmd_pkg::op_set_freq_div)
				exp_dly[t][l][(b[6] ? 14 : 12) +: 2] = b[5:4];
		end
	endtask

	task automatic check_field(input string name, input int l, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got == exp) else begin
			$display("FAIL %s[%0d]: got %h expected %h", name, l, got, exp);
			errors++;
		end
	endtask

	task automatic check_outputs();
		int l;
		for (l = 0; l < nl; l++) begin
			check_field("test", l, 16'(test[l*line_pkg::test_w +: line_pkg::test_w]),
				16'(exp_test[l]));
			check_field("leds", l, 16'(leds[l*line_pkg::led_w +: line_pkg::led_w]),
				16'(exp_leds[l]));
			check_field("cross_idx", l, cross_idx[l*dw +: dw], exp_dly[0][l]);
			check_field("auto_idx", l, auto_idx[l*dw +: dw], exp_dly[1][l]);
			check_field("cross_len", l, cross_len[l*dw +: dw], exp_dly[2][l]);
			check_field("auto_len", l, auto_len[l*dw +: dw], exp_dly[3][l]);
		end
	endtask

	task automatic hold_bit(input logic v, input int per);
		rx <= v;
		repeat (per) @(posedge clk);
	endtask

	// One frame, LSB first. A low stop bit makes the receiver drop the byte.
	task automatic send_frame(input logic [7:0] b, input bit stop_ok);
		int i;
		int n;
		int per;
		int want;
		settled = 1'b0;
		per = cycles_per_bit(tb_baud);
		want = frames_seen + (stop_ok ? 1 : 0);
		hold_bit(1'b0, per);
		for (i = 0; i < 8; i++)
			hold_bit(b[i], per);
		hold_bit(stop_ok, per);
		rx <= 1'b1;
		n = 0;
		while (frames_seen != want && n < 4 * per) begin
			@(posedge clk);
			n++;
		end
		if (frames_seen != want)
			$display("Timeout: the receiver did not deliver byte %h", b);
		repeat (4) @(posedge clk);
		assert (frames_seen == want) else begin
			$display("FAIL frames_seen after byte %h: got %h expected %h", b, frames_seen, want);
			errors++;
		end
		if (stop_ok)
			apply_byte(b);
		check_outputs();
		settled = 1'b1;
		@(posedge clk); // One edge with the model settled for the concurrent checks.
	endtask

	task automatic select_line(input logic [7:0] ln);
		int p;
		for (p = 0; p < 4; p++)
			send_frame({p[1:0], ln[2*p +: 2], cmd_pkg::op_set_line}, 1'b1);
	endtask

	task automatic measure_pwm();
		int hi [nl];
		int c;
		int l;
		hi = '{default: 0};
		for (c = 0; c < (1 << line_pkg::pwm_cnt_w); c++) begin
			@(negedge clk);
			for (l = 0; l < nl; l++)
				hi[l] += int'(pwm[l]);
		end
		for (l = 0; l < nl; l++) begin
			assert (hi[l] == int'(exp_volt[l])) else begin
				$display("FAIL pwm[%0d] high cycles: got %h expected %h", l, hi[l], exp_volt[l]);
				errors++;
			end
		end
		@(posedge clk);
	endtask

	initial begin
		int i;
		int l;
		int p;
		int r;
		logic [7:0] v;
		clk = 1'b0;
		rst = 1'b1;
		rx = 1'b1;
		seed = 6005;
		errors = 0;
		settled = 1'b0;
		cur_line = '0;
		tb_baud = '0;
		exp_flags = 4'b0100; // Only timestamp_reset is set after reset.
		exp_volt = '{default: '0};
		exp_test = '{default: '0};
		exp_leds = '{default: '0};
		exp_dly = '{default: '{default: '0}};
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_outputs();
		settled = 1'b1;
		measure_pwm();

		for (l = 0; l < nl; l++) begin
			r = $random(seed);
			select_line(8'(l));
			send_frame({1'b0, r[18:16], cmd_pkg::op_enable_capture}, 1'b1);
			send_frame({r[3:0], cmd_pkg::op_enable_test}, 1'b1);
			send_frame({r[7:4], cmd_pkg::op_set_leds}, 1'b1);
			send_frame({1'b1, r[21:19], cmd_pkg::op_enable_capture}, 1'b1);
			send_frame({r[11:8], cmd_pkg::op_enable_test}, 1'b1);
			send_frame({r[15:12], cmd_pkg::op_set_leds}, 1'b1);
		end

		for (l = 0; l < nl; l++) begin
			select_line(8'(l));
			for (i = 0; i < 10; i++) begin
				r = $random(seed);
				if (i % 5 == 0)
					send_frame({i == 5, r[22:20], cmd_pkg::op_enable_capture}, 1'b1);
				v = {r[7:4], r[8] ? cmd_pkg::op_set_freq_div : {2'b01, r[1:0]}};
				send_frame(v, 1'b1);
			end
		end
		select_line(8'd1);
		send_frame({4'h0, cmd_pkg::op_clear}, 1'b1);

		for (l = 0; l < nl; l++) begin
			v = 8'($random(seed));
			select_line(8'(l));
			for (p = 0; p < 4; p++)
				send_frame({p[1:0], v[2*p +: 2], cmd_pkg::op_set_voltage}, 1'b1);
		end
		measure_pwm();

		r = $random(seed);
		send_frame({r[3:0], cmd_pkg::op_set_baud_rate}, 1'b1);
		send_frame({r[7:4], cmd_pkg::op_enable_test}, 1'b1);
		send_frame({r[11:8], cmd_pkg::op_set_leds}, 1'b1);
		send_frame({r[15:12], 2'b01, r[17:16]}, 1'b1);
		send_frame({4'h0, cmd_pkg::op_set_baud_rate}, 1'b1);

		r = $random(seed);
		send_frame({r[3:0], 4'd10}, 1'b1);
		send_frame({r[7:4], 4'd11}, 1'b1);
		send_frame({r[11:8], 4'd14}, 1'b1);
		send_frame({r[15:12], 4'd15}, 1'b1);
		select_line(8'd4 + 8'(r[23:16] % 8'd252)); // Any line past the last one.
		send_frame({4'h0, cmd_pkg::op_clear}, 1'b1);
		send_frame({4'hf, cmd_pkg::op_set_voltage}, 1'b1);
		send_frame({4'h5, cmd_pkg::op_enable_test}, 1'b1);
		send_frame({4'ha, cmd_pkg::op_set_leds}, 1'b1);
		send_frame({4'h7, cmd_pkg::op_set_delay}, 1'b1);
		send_frame({4'h3, cmd_pkg::op_set_freq_div}, 1'b1);
		select_line(8'd0);
		send_frame({4'hf, cmd_pkg::op_enable_capture}, 1'b0);
		send_frame({4'ha, cmd_pkg::op_enable_test}, 1'b0);
		measure_pwm();

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* corr_ctrl_top.sv */
//****************************************************************************
// Control front end of the correlator. Serial commands come in on rx and
// set the per-line configuration, which leaves as plain level outputs
// together with one PWM bias output per line.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module corr_ctrl_top #(
	parameter bit has_leds = 1'b1
) (
	input  wire                                                 clk,
	input  wire                                                 rst,
	input  wire                                                 rx,
	output logic [line_pkg::num_lines-1:0]                      pwm,
	output logic [line_pkg::num_lines*line_pkg::test_w-1:0]     test,
	output logic [line_pkg::num_lines*line_pkg::led_w-1:0]      leds,
	output logic [line_pkg::num_lines*line_pkg::dly_w-1:0]      cross_idx,
	output logic [line_pkg::num_lines*line_pkg::dly_w-1:0]      auto_idx,
	output logic [line_pkg::num_lines*line_pkg::dly_w-1:0]      cross_len,
	output logic [line_pkg::num_lines*line_pkg::dly_w-1:0]      auto_len,
	output logic                                                integrating,
	output logic                                                external_clock,
	output logic                                                timestamp_reset,
	output logic                                                extra_commands
);

	logic [7:0] byte_data;
	logic byte_valid;
	logic [cmd_pkg::baud_sel_w-1:0] baud_sel;

	line_cfg_if cfg ();

	uart_rx uart_rx_i (
		.clk        (clk),
		.rst        (rst),
		.rx         (rx),
		.baud_sel   (baud_sel),   // Fed back from the parser.
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	cmd_parser #(
		.has_leds (has_leds)
	) cmd_parser_i (
		.clk             (clk),
		.rst             (rst),
		.byte_data       (byte_data),
		.byte_valid      (byte_valid),
		.baud_sel        (baud_sel),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset),
		.extra_commands  (extra_commands),
		.cfg             (cfg)
	);

	pwm_bank pwm_bank_i (
		.clk (clk),
		.rst (rst),
		.cfg (cfg),
		.pwm (pwm)
	);

	assign test      = cfg.test;
	assign leds      = cfg.leds;
	assign cross_idx = cfg.cross_idx;
	assign auto_idx  = cfg.auto_idx;
	assign cross_len = cfg.cross_len;
	assign auto_len  = cfg.auto_len;

endmodule

`default_nettype wire

/* pwm_bank.sv */
//****************************************************************************
// PWM outputs for the line bias voltages. A shared free-running counter is
// compared with each line's voltage, so a line is high for that many
// cycles out of every counter period.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pwm_bank (
	input  wire                              clk,
	input  wire                              rst,
	line_cfg_if.pwm                          cfg,
	output logic [line_pkg::num_lines-1:0]   pwm
);

	logic [line_pkg::pwm_cnt_w-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1; // Wraps after 255.
	end

	for (genvar i = 0; i < line_pkg::num_lines; i++) begin : g_line
		logic [line_pkg::volt_w-1:0] level;

		assign level = cfg.voltage[i*line_pkg::volt_w +: line_pkg::volt_w];

		always_ff @(posedge clk) begin
			if (rst)
				pwm[i] <= 1'b0;
			else
				pwm[i] <= cnt < level;
		end

		assert property (@(posedge clk) disable iff (rst) pwm[i] |-> $past(level) != '0)
			else $error("pwm_bank: line %0d high with zero voltage", i);
	end

endmodule

`default_nettype wire

/* cmd_parser.sv */
//****************************************************************************
// Command decoder for the serial control port. Each received byte carries
// an opcode in its low nibble and a small value in its high nibble, which
// is written into the flags, the baud selection or a field of one line.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module cmd_parser #(
	parameter bit has_leds = 1'b0
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire [7:0]                          byte_data,
	input  wire                                byte_valid,
	output logic [cmd_pkg::baud_sel_w-1:0]     baud_sel,
	output logic                               integrating,
	output logic                               external_clock,
	output logic                               timestamp_reset,
	output logic                               extra_commands,
	line_cfg_if.parser                         cfg
);

	logic [cmd_pkg::op_w-1:0] op;
	logic [line_pkg::line_sel_w-1:0] current_line;
	logic [line_pkg::line_idx_w-1:0] ln;
	logic line_ok;
	logic [1:0] tgt;
	int unsigned dly_lsb;
	int unsigned div_lsb;

	assign op      = byte_data[cmd_pkg::op_w-1:0];
	assign ln      = current_line[line_pkg::line_idx_w-1:0];
	assign line_ok = current_line < line_pkg::line_sel_w'(line_pkg::num_lines);

	// Length over index from extra_commands, auto over cross from bit 7.
	assign tgt = {extra_commands, byte_data[7]};

	assign dly_lsb = ln * line_pkg::dly_w + byte_data[1:0] * cmd_pkg::dly_grp_w;
	assign div_lsb = ln * line_pkg::dly_w + cmd_pkg::div_base
		+ byte_data[6] * cmd_pkg::div_grp_w;

	always_ff @(posedge clk) begin
		if (rst) begin
			current_line    <= '0;
			baud_sel        <= '0;
			integrating     <= 1'b0;
			external_clock  <= 1'b0;
			timestamp_reset <= 1'b1; // Timestamps are held until capture is set up.
			extra_commands  <= 1'b0;
			cfg.voltage     <= '0;
			cfg.test        <= '0;
			cfg.leds        <= '0;
			cfg.cross_idx   <= '0;
			cfg.auto_idx    <= '0;
			cfg.cross_len   <= '0;
			cfg.auto_len    <= '0;
		end else if (byte_valid) begin
			unique case (op)
				cmd_pkg::op_set_line:
					current_line[byte_data[7:6]*cmd_pkg::pair_w +: cmd_pkg::pair_w] <= byte_data[5:4];
				cmd_pkg::op_enable_capture: begin
					integrating     <= byte_data[4];
					external_clock  <= byte_data[5];
					timestamp_reset <= byte_data[6];
					extra_commands  <= byte_data[7];
				end
				cmd_pkg::op_set_baud_rate:
					baud_sel <= byte_data[7:4];
				cmd_pkg::op_clear: if (line_ok) begin
					cfg.cross_idx[ln*line_pkg::dly_w +: line_pkg::dly_w] <= '0;
					cfg.auto_idx[ln*line_pkg::dly_w +: line_pkg::dly_w]  <= '0;
				end
				cmd_pkg::op_set_voltage: if (line_ok) begin
					cfg.voltage[ln*line_pkg::volt_w + byte_data[7:6]*cmd_pkg::pair_w
						+: cmd_pkg::pair_w] <= byte_data[5:4];
				end
				cmd_pkg::op_enable_test: if (line_ok) begin
					cfg.test[ln*line_pkg::test_w + extra_commands*cmd_pkg::nib_w
						+: cmd_pkg::nib_w] <= byte_data[7:4];
				end
				cmd_pkg::op_set_leds: if (line_ok && has_leds) begin
					cfg.leds[ln*line_pkg::led_w + extra_commands*cmd_pkg::nib_w
						+: cmd_pkg::nib_w] <= byte_data[7:4];
				end
				cmd_pkg::op_set_freq_div: if (line_ok) begin
					unique case (tgt)
						2'b00: cfg.cross_idx[div_lsb +: cmd_pkg::div_grp_w] <= byte_data[5:4];
						2'b01: cfg.auto_idx[div_lsb +: cmd_pkg::div_grp_w]  <= byte_data[5:4];
						2'b10: cfg.cross_len[div_lsb +: cmd_pkg::div_grp_w] <= byte_data[5:4];
						2'b11: cfg.auto_len[div_lsb +: cmd_pkg::div_grp_w]  <= byte_data[5:4];
					endcase
				end
				default: begin
					// Any opcode 01xx is a delay write; the rest are unused.
					if (line_ok && (op & cmd_pkg::op_delay_mask) == cmd_pkg::op_set_delay) begin
						unique case (tgt)
							2'b00: cfg.cross_idx[dly_lsb +: cmd_pkg::dly_grp_w] <= byte_data[6:4];
							2'b01: cfg.auto_idx[dly_lsb +: cmd_pkg::dly_grp_w]  <= byte_data[6:4];
							2'b10: cfg.cross_len[dly_lsb +: cmd_pkg::dly_grp_w] <= byte_data[6:4];
							2'b11: cfg.auto_len[dly_lsb +: cmd_pkg::dly_grp_w]  <= byte_data[6:4];
						endcase
					end
				end
			endcase
		end
	end

	// Line fields move only on the cycle after a received byte.
	assert property (@(posedge clk) disable iff (rst)
		!byte_valid |=> $stable({cfg.voltage, cfg.test, cfg.leds, cfg.cross_idx,
			cfg.auto_idx, cfg.cross_len, cfg.auto_len}))
		else $error("cmd_parser: line field changed without a received byte");

endmodule

`default_nettype wire

/* uart_rx.sv */
//****************************************************************************
// Serial receiver, 8 data bits, no parity, one stop bit, LSB first.
// The bit period is taken from baud_sel at each start bit and every byte
// with a high stop bit is handed on with a one-cycle byte_valid strobe.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            rx,
	input  wire [cmd_pkg::baud_sel_w-1:0]  baud_sel,
	output logic [7:0]                     byte_data,
	output logic                           byte_valid
);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [cmd_pkg::bit_cnt_w-1:0] bit_len;
	logic [cmd_pkg::bit_cnt_w-1:0] cnt;
	logic [2:0] bit_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1; // Line idles high.
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			cnt        <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (state != st_idle && cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				unique case (state)
					st_idle: if (rx_prev && !rx_sync) begin
						// First wait is half a bit so that sampling lands mid-bit.
						bit_len <= cmd_pkg::bit_cycles(baud_sel);
						cnt     <= (cmd_pkg::bit_cycles(baud_sel) >> 1) - 1'b1;
						state   <= st_start;
					end
					st_start: begin
						cnt     <= bit_len - 1'b1;
						bit_idx <= '0;
						state   <= rx_sync ? st_idle : st_data; // A short glitch is ignored.
					end
					st_data: begin
						byte_data <= {rx_sync, byte_data[7:1]};
						cnt       <= bit_len - 1'b1;
						bit_idx   <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
					st_stop: begin
						byte_valid <= rx_sync; // Bytes with a low stop bit are dropped.
						state      <= st_idle;
					end
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) byte_valid |=> !byte_valid)
		else $error("uart_rx: byte_valid held for more than one cycle");

endmodule

`default_nettype wire

/* line_cfg_if.sv */
//****************************************************************************
// Per-line configuration registers as packed buses, one field per line.
// The command parser drives them, the PWM bank reads the voltages and the
// top level brings the rest out.
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

interface line_cfg_if;

	logic [line_pkg::num_lines*line_pkg::volt_w-1:0] voltage;
	logic [line_pkg::num_lines*line_pkg::test_w-1:0] test;
	logic [line_pkg::num_lines*line_pkg::led_w-1:0]  leds;
	logic [line_pkg::num_lines*line_pkg::dly_w-1:0]  cross_idx;
	logic [line_pkg::num_lines*line_pkg::dly_w-1:0]  auto_idx;
	logic [line_pkg::num_lines*line_pkg::dly_w-1:0]  cross_len;
	logic [line_pkg::num_lines*line_pkg::dly_w-1:0]  auto_len;

	modport parser (
		output voltage, test, leds,
		output cross_idx, auto_idx, cross_len, auto_len
	);

	modport pwm (
		input voltage
	);

	modport top (
		input test, leds,
		input cross_idx, auto_idx, cross_len, auto_len
	);

endinterface

`default_nettype wire

/* line_pkg.sv */
//****************************************************************************
// Geometry of the correlator lines: how many there are, the width of the
// line selection and the size of every per-line configuration field.
//****************************************************************************

`default_nettype none

package line_pkg;

	localparam int unsigned num_lines = 4;

	// Selection is wider than needed; lines past num_lines are not written.
	localparam int unsigned line_sel_w = 8;
	localparam int unsigned line_idx_w = $clog2(num_lines);

	localparam int unsigned volt_w = 8;
	localparam int unsigned test_w = 8;
	localparam int unsigned led_w  = 8;

	// Index and length: delay groups in bits 0 to 11, divider in 12 to 15.
	localparam int unsigned dly_w = 16;

	localparam int unsigned pwm_cnt_w = 8; // One PWM period is 256 cycles.

endpackage

`default_nettype wire

/* cmd_pkg.sv */
//****************************************************************************
// Command set of the serial control port: opcode values, bit-field sizes
// of the command byte and the rule that turns a baud selection into a
// bit period in clock cycles.
//****************************************************************************

`default_nettype none

package cmd_pkg;

	localparam int unsigned op_w = 4; // Opcode sits in the low nibble.

	localparam logic [op_w-1:0] op_clear          = 4'd0;
	localparam logic [op_w-1:0] op_set_line       = 4'd1;
	localparam logic [op_w-1:0] op_set_leds       = 4'd2;
	localparam logic [op_w-1:0] op_set_baud_rate  = 4'd3;
	localparam logic [op_w-1:0] op_set_delay      = 4'd4;
	localparam logic [op_w-1:0] op_set_freq_div   = 4'd8;
	localparam logic [op_w-1:0] op_set_voltage    = 4'd9;
	localparam logic [op_w-1:0] op_enable_test    = 4'd12;
	localparam logic [op_w-1:0] op_enable_capture = 4'd13;

	// Opcodes 4 to 7 are all delay writes.
	localparam logic [op_w-1:0] op_delay_mask = 4'b1100;

	localparam int unsigned pair_w    = 2; // Line number and voltage pairs.
	localparam int unsigned nib_w     = 4; // Test and LED nibbles.
	localparam int unsigned dly_grp_w = 3;
	localparam int unsigned div_grp_w = 2;
	localparam int unsigned div_base  = 12; // Divider bits sit above the delay bits.

	localparam int unsigned baud_sel_w      = 4;
	localparam int unsigned base_bit_cycles = 8;
	localparam int unsigned max_baud_sel    = 7;
	localparam int unsigned bit_cnt_w       = $clog2((base_bit_cycles << max_baud_sel) + 1);

	// Bit period doubles with each step of the selection, clamped at the top.
	function automatic logic [bit_cnt_w-1:0] bit_cycles(input logic [baud_sel_w-1:0] sel);
		logic [baud_sel_w-1:0] eff;
		eff = (sel > baud_sel_w'(max_baud_sel)) ? baud_sel_w'(max_baud_sel) : sel;
		return bit_cnt_w'(base_bit_cycles) << eff;
	endfunction

endpackage

`default_nettype wire
